// ==== src/dp_cfg_pkg.sv ====
// datapath sizes and types; inputs to the adder must already be below Q_MOD, NUM_COEF is 2**IDX_WIDTH
package dp_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // store geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam int COE_WIDTH     = 39;
    localparam int ADDR_WIDTH    = 4;                        // 16 rows per bank
    localparam int NUM_BASE_BANK = 8;                        // banks per poly
    localparam int LOG_NUM_BANK  = 3;                        // bank select width
    localparam int NUM_POLY      = 3;                        // polys per polyvec
    localparam int NUM_BANK      = NUM_BASE_BANK * NUM_POLY; // 24
    localparam int IDX_WIDTH     = ADDR_WIDTH + LOG_NUM_BANK;
    localparam int NUM_COEF      = NUM_BASE_BANK * (1 << ADDR_WIDTH); // 128 per poly

    // modulus 2^39 - 7
    localparam logic [COE_WIDTH-1:0] Q_MOD = 39'h7F_FFFF_FFF9;

    ////////////////////////////////////////////////////////////////////////////
    // pipeline depths
    ////////////////////////////////////////////////////////////////////////////
    localparam int PSUM_DELAY = 2;                       // external psum buffer latency
    localparam int ADD_DELAY  = 1;                       // adder output register
    localparam int WB_DELAY   = PSUM_DELAY + ADD_DELAY;  // address to write-back

    ////////////////////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [COE_WIDTH-1:0] coe_t;

    // one coefficient per poly, poly 0 in the low bits
    typedef coe_t [NUM_POLY-1:0] lane_vec_t;

    // axi bank write, bank b belongs to poly b / NUM_BASE_BANK
    typedef struct packed {
        logic [NUM_BANK-1:0]                      we;    // per bank mask
        logic [NUM_BASE_BANK-1:0][ADDR_WIDTH-1:0] addr;  // row, shared across polys
        coe_t [NUM_BASE_BANK-1:0]                 data;  // shared across polys
    } axi_wr_t;

    // accumulated result toward the psum buffer
    typedef struct packed {
        logic                 we;
        logic [IDX_WIDTH-1:0] idx;   // linear coefficient index
        lane_vec_t            data;
    } madd_wr_t;

endpackage

// ==== src/dp_ctrl_pkg.sv ====
// madd sequencer encodings; flush length follows the write-back depth of the datapath
package dp_ctrl_pkg;

    // sequencer states, reset lands in MS_DONE (nothing pending)
    typedef enum logic [1:0] {
        MS_IDLE  = 2'd0,   // loaded, waiting for start
        MS_RUN   = 2'd1,   // issuing addresses
        MS_FLUSH = 2'd2,   // pipeline draining
        MS_DONE  = 2'd3    // result complete, waiting for swap
    } madd_state_t;

    // cycles from last issue until the last write-back leaves
    localparam int FLUSH_CYCLES = dp_cfg_pkg::WB_DELAY;
    localparam int FLUSH_CNT_W  = $clog2(FLUSH_CYCLES + 1);

endpackage

// ==== src/dp_madd_fsm.sv ====
// start is honoured only in idle; i_axi_done is a level and must drop after the swap it caused
`timescale 1ns/1ps

module dp_madd_fsm (
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_madd_start,   // one cycle pulse
    input  logic i_axi_done,     // load set complete
    input  logic i_issue_last,   // counter is issuing the final index
    input  logic i_drained,      // final tag at write-back
    output logic o_run,
    output logic o_swap,
    output logic o_madd_done
);
    import dp_ctrl_pkg::*;

    madd_state_t            state_q;
    madd_state_t            state_d;
    logic [FLUSH_CNT_W-1:0] flush_cnt_q;   // cycles spent in flush
    logic                   flush_end;

    // drained and the count coincide; the count bounds the wait
    assign flush_end = i_drained || (flush_cnt_q == FLUSH_CNT_W'(FLUSH_CYCLES - 1));

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            MS_IDLE: begin
                if (i_madd_start) begin
                    state_d = MS_RUN;
                end
            end
            MS_RUN: begin
                if (i_issue_last) begin   // 128th address this cycle
                    state_d = MS_FLUSH;
                end
            end
            MS_FLUSH: begin
                if (flush_end) begin
                    state_d = MS_DONE;
                end
            end
            MS_DONE: begin
                if (i_axi_done) begin     // swap now, new set ready
                    state_d = MS_IDLE;
                end
            end
            default: state_d = MS_DONE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q     <= MS_DONE;   // nothing pending after reset
            flush_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == MS_FLUSH) begin
                flush_cnt_q <= flush_cnt_q + 1'b1;
            end else begin
                flush_cnt_q <= '0;
            end
        end
    end

    assign o_run       = (state_q == MS_RUN);
    assign o_madd_done = (state_q == MS_DONE);
    assign o_swap      = (state_q == MS_DONE) && i_axi_done;   // roles flip on next edge

endmodule

// ==== src/dp_addr_counter.sv ====
// one index per cycle while i_run is high; the tag line assumes a write-back path that never stalls
`timescale 1ns/1ps

module dp_addr_counter (
    input  logic                           clk,
    input  logic                           i_arst_n,
    input  logic                           i_run,
    output logic [dp_cfg_pkg::IDX_WIDTH-1:0] o_idx,         // read index, banks and psum buffer
    output logic                           o_issue_last,
    output logic                           o_wb_we,
    output logic [dp_cfg_pkg::IDX_WIDTH-1:0] o_wb_idx,
    output logic                           o_drained      // last tag at write-back
);
    import dp_cfg_pkg::*;

    // tag riding alongside each index
    typedef struct packed {
        logic                 vld;
        logic                 last;
        logic [IDX_WIDTH-1:0] idx;
    } wb_tag_t;

    logic [IDX_WIDTH-1:0]      idx_q;
    wb_tag_t                   tag_in;
    wb_tag_t [WB_DELAY-1:0]    tag_q;    // [0] newest, [WB_DELAY-1] at write-back

    assign o_issue_last = i_run && (idx_q == IDX_WIDTH'(NUM_COEF - 1));

    ////////////////////////////////////////////////////////////////////////////
    // issue side
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            idx_q <= '0;
        end else if (o_issue_last) begin
            idx_q <= '0;                 // ready for next run
        end else if (i_run) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    assign o_idx = idx_q;

    ////////////////////////////////////////////////////////////////////////////
    // write-back tag line
    ////////////////////////////////////////////////////////////////////////////
    assign tag_in = '{vld: i_run, last: o_issue_last, idx: idx_q};

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            tag_q <= '0;
        end else begin
            tag_q <= {tag_q[WB_DELAY-2:0], tag_in};   // several indices in flight
        end
    end

    assign o_wb_we   = tag_q[WB_DELAY-1].vld;
    assign o_wb_idx  = tag_q[WB_DELAY-1].idx;
    assign o_drained = tag_q[WB_DELAY-1].vld && tag_q[WB_DELAY-1].last;

endmodule

// ==== src/dp_pingpong_banks.sv ====
// index = {row, bank}; swap only when no read is in flight, axi writes always go to the load set
`timescale 1ns/1ps

module dp_pingpong_banks (
    input  logic                             clk,
    input  logic                             i_arst_n,
    input  logic                             i_swap,     // flip load/compute roles
    input  dp_cfg_pkg::axi_wr_t              i_axi_wr,
    input  logic [dp_cfg_pkg::IDX_WIDTH-1:0] i_rd_idx,
    output dp_cfg_pkg::lane_vec_t            o_coef      // aligned with psum return
);
    import dp_cfg_pkg::*;

    coe_t                    mem [2][NUM_BANK][1 << ADDR_WIDTH];   // set, bank, row
    logic                    comp_sel_q;   // set being read by madd
    logic                    load_sel;     // set taking axi writes
    logic [ADDR_WIDTH-1:0]   rd_row;
    logic [LOG_NUM_BANK-1:0] rd_bank;
    logic [LOG_NUM_BANK-1:0] bank_q;
    coe_t [NUM_BANK-1:0]     row_q;        // whole row of every bank
    lane_vec_t               lane_sel;
    lane_vec_t [PSUM_DELAY-2:0] lane_pipe_q;

    assign load_sel = ~comp_sel_q;
    assign rd_row   = i_rd_idx[IDX_WIDTH-1:LOG_NUM_BANK];   // high bits
    assign rd_bank  = i_rd_idx[LOG_NUM_BANK-1:0];           // low bits

    ////////////////////////////////////////////////////////////////////////////
    // role bit
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            comp_sel_q <= 1'b0;   // set 0 compute, set 1 load
        end else if (i_swap) begin
            comp_sel_q <= ~comp_sel_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // axi write port
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int b = 0; b < NUM_BANK; b++) begin
            // addr/data are per base bank, shared by the three polys
            if (i_axi_wr.we[b]) begin
                mem[load_sel][b][i_axi_wr.addr[b % NUM_BASE_BANK]] <=
                    i_axi_wr.data[b % NUM_BASE_BANK];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // compute read path
    ////////////////////////////////////////////////////////////////////////////
    // stage 1, registered row read like a bram port
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            row_q  <= '0;
            bank_q <= '0;
        end else begin
            for (int b = 0; b < NUM_BANK; b++) begin
                row_q[b] <= mem[comp_sel_q][b][rd_row];
            end
            bank_q <= rd_bank;   // select follows its row
        end
    end

    // pick one bank per poly
    always_comb begin
        for (int p = 0; p < NUM_POLY; p++) begin
            lane_sel[p] = row_q[p * NUM_BASE_BANK + bank_q];
        end
    end

    // remaining stages up to PSUM_DELAY
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            lane_pipe_q <= '0;
        end else begin
            lane_pipe_q[0] <= lane_sel;
            for (int s = 1; s < PSUM_DELAY - 1; s++) begin
                lane_pipe_q[s] <= lane_pipe_q[s-1];
            end
        end
    end

    assign o_coef = lane_pipe_q[PSUM_DELAY-2];

endmodule

// ==== src/dp_mod_add.sv ====
// single conditional subtract; both operands must already be below Q_MOD
`timescale 1ns/1ps

module dp_mod_add (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  dp_cfg_pkg::lane_vec_t i_coef,   // stored coefficient per poly
    input  dp_cfg_pkg::lane_vec_t i_psum,   // partial sum per poly
    output dp_cfg_pkg::lane_vec_t o_sum     // registered, one cycle
);
    import dp_cfg_pkg::*;

    logic [NUM_POLY-1:0][COE_WIDTH:0] sum_raw;   // carry bit kept
    logic [NUM_POLY-1:0][COE_WIDTH:0] sum_sub;
    lane_vec_t                        sum_red;

    ////////////////////////////////////////////////////////////////////////////
    // lanes
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int p = 0; p < NUM_POLY; p++) begin
            sum_raw[p] = {1'b0, i_coef[p]} + {1'b0, i_psum[p]};
            sum_sub[p] = sum_raw[p] - {1'b0, Q_MOD};
            // a + b < 2Q so one subtract is enough
            if (sum_raw[p] >= {1'b0, Q_MOD}) begin
                sum_red[p] = sum_sub[p][COE_WIDTH-1:0];
            end else begin
                sum_red[p] = sum_raw[p][COE_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_sum <= '0;
        end else begin
            o_sum <= sum_red;   // ADD_DELAY stage
        end
    end

endmodule

// ==== src/dp_top.sv ====
// psum buffer must answer exactly PSUM_DELAY cycles after o_madd_rdaddr; write-back is never stalled
`timescale 1ns/1ps

module dp_top (
    input  logic                             clk,
    input  logic                             i_arst_n,
    // axi writer
    input  dp_cfg_pkg::axi_wr_t              i_axi_wr,
    input  logic                             i_axi_done,      // level, load set complete
    // madd control
    input  logic                             i_madd_start,    // one cycle pulse
    output logic                             o_madd_done,     // level
    // psum buffer
    output logic [dp_cfg_pkg::IDX_WIDTH-1:0] o_madd_rdaddr,
    input  dp_cfg_pkg::lane_vec_t            i_madd_data,     // PSUM_DELAY after address
    output dp_cfg_pkg::madd_wr_t             o_madd_wr
);
    import dp_cfg_pkg::*;

    logic                 run;
    logic                 swap;
    logic                 issue_last;
    logic                 drained;
    logic [IDX_WIDTH-1:0] rd_idx;
    logic                 wb_we;
    logic [IDX_WIDTH-1:0] wb_idx;
    lane_vec_t            bank_coef;   // lined up with i_madd_data
    lane_vec_t            madd_sum;

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////
    dp_madd_fsm u_fsm (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_madd_start (i_madd_start),
        .i_axi_done   (i_axi_done),
        .i_issue_last (issue_last),
        .i_drained    (drained),
        .o_run        (run),
        .o_swap       (swap),
        .o_madd_done  (o_madd_done)
    );

    dp_addr_counter u_cnt (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_run        (run),
        .o_idx        (rd_idx),
        .o_issue_last (issue_last),
        .o_wb_we      (wb_we),
        .o_wb_idx     (wb_idx),
        .o_drained    (drained)
    );

    assign o_madd_rdaddr = rd_idx;   // same index feeds banks and psum buffer

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////
    dp_pingpong_banks u_banks (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_swap   (swap),
        .i_axi_wr (i_axi_wr),
        .i_rd_idx (rd_idx),
        .o_coef   (bank_coef)
    );

    dp_mod_add u_add (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_coef   (bank_coef),
        .i_psum   (i_madd_data),
        .o_sum    (madd_sum)
    );

    // tag and sum both land WB_DELAY after the address
    assign o_madd_wr = '{we: wb_we, idx: wb_idx, data: madd_sum};

endmodule

// ==== dv/dp_top_tb.sv ====
// testbench for dp_top; psum buffer modeled at a fixed 2-cycle latency and sums are not fed back into it
`timescale 1ns/1ps

module dp_top_tb;
    import dp_cfg_pkg::*;

    typedef enum {MODE_RAND, MODE_NEAR_Q, MODE_ZERO} coef_mode_e;

    localparam int NUM_TESTS      = 4;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 250 + 100;
    localparam int ROWS           = 1 << ADDR_WIDTH;

    // stimulus table
    string      test_name    [NUM_TESTS];
    coef_mode_e test_mode    [NUM_TESTS];
    logic       test_overlap [NUM_TESTS];   // load next entry during this run

    logic                 clk;
    logic                 i_arst_n;
    axi_wr_t              i_axi_wr;
    logic                 i_axi_done;
    logic                 i_madd_start;
    logic                 o_madd_done;
    logic [IDX_WIDTH-1:0] o_madd_rdaddr;
    lane_vec_t            i_madd_data;
    madd_wr_t             o_madd_wr;

    // reference model state
    coe_t                 load_coef [NUM_POLY][NUM_COEF];   // set being loaded
    coe_t                 load_psum [NUM_POLY][NUM_COEF];
    coe_t                 run_coef  [NUM_POLY][NUM_COEF];   // set being read
    coe_t                 psum_tab  [NUM_POLY][NUM_COEF];   // psum buffer contents
    logic [IDX_WIDTH-1:0] rd_hist   [4];                    // [k] = address k cycles ago

    int    seed;
    int    cycle_cnt;
    int    check_cnt;
    int    err_cnt;
    int    mismatch_cnt;
    int    wb_count;
    int    first_wb_cycle;
    int    last_wb_cycle;
    logic  wb_expect;   // a run is active
    logic  preloaded;   // next set already written
    string cur_name;

    dp_top dut0 (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_axi_wr      (i_axi_wr),
        .i_axi_done    (i_axi_done),
        .i_madd_start  (i_madd_start),
        .o_madd_done   (o_madd_done),
        .o_madd_rdaddr (o_madd_rdaddr),
        .i_madd_data   (i_madd_data),
        .o_madd_wr     (o_madd_wr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    // hang guard
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("ERROR: timeout after %0d cycles, a run never finished", cycle_cnt);
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference helpers
    ////////////////////////////////////////////////////////////////////////////
    // (a + b) mod q in 64 bits so nothing wraps
    function automatic coe_t mod_sum_ref(input coe_t a, input coe_t b);
        logic [63:0] s;
        s = 64'(a) + 64'(b);
        return coe_t'(s % 64'(Q_MOD));
    endfunction

    function automatic coe_t draw_value(input coef_mode_e mode, input logic is_coef);
        logic [63:0] r;
        coe_t        v;
        r = {32'($random(seed)), 32'($random(seed))};
        v = r[COE_WIDTH-1:0];
        case (mode)
            MODE_NEAR_Q: v = Q_MOD - 39'd1 - coe_t'(r[15:0]);   // top 64k of the range
            MODE_ZERO:   if (is_coef) v = '0;                    // psum stays random
            default:     v = r[COE_WIDTH-1:0];
        endcase
        if (v >= Q_MOD) v = v - Q_MOD;   // keep operands below q
        return v;
    endfunction

    task automatic step;
        @(posedge clk);
        #5;   // drive and sample away from the edge
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        mismatch_cnt++;
        err_cnt++;
        $display("Mismatch %s %s: expected %h actual %h", cur_name, what, exp_v, act_v);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // psum buffer model and write-back monitor
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_wb;
        coe_t exp_v;
        int   idx;
        idx = int'(o_madd_wr.idx);
        if (!wb_expect) begin
            err_cnt++;
            $display("ERROR: write-back at index %0d while no run was started", idx);
        end else if (wb_count >= NUM_COEF) begin
            err_cnt++;
            $display("ERROR: %s: extra write-back at index %0d after all %0d coefficients",
                     cur_name, idx, NUM_COEF);
        end else begin
            check_cnt++;
            if (idx != wb_count) begin
                report_mismatch("index", 64'(wb_count), 64'(idx));
            end
            if (rd_hist[3] != IDX_WIDTH'(wb_count)) begin   // address leads by WB_DELAY
                report_mismatch($sformatf("address 3 cycles before write-back %0d", wb_count),
                                64'(wb_count), 64'(rd_hist[3]));
            end
            for (int p = 0; p < NUM_POLY; p++) begin
                exp_v = mod_sum_ref(run_coef[p][wb_count], psum_tab[p][wb_count]);
                if (o_madd_wr.data[p] != exp_v) begin
                    report_mismatch($sformatf("lane %0d idx %0d", p, wb_count),
                                    64'(exp_v), 64'(o_madd_wr.data[p]));
                end
            end
        end
        if (wb_count == 0) first_wb_cycle = cycle_cnt;
        wb_count++;
        last_wb_cycle = cycle_cnt;
    endtask

    initial begin
        i_madd_data = '0;
        for (int j = 0; j < 4; j++) rd_hist[j] = '0;
        forever begin
            step;
            for (int j = 3; j > 0; j--) rd_hist[j] = rd_hist[j-1];
            rd_hist[0] = o_madd_rdaddr;
            for (int p = 0; p < NUM_POLY; p++) begin
                i_madd_data[p] = psum_tab[p][rd_hist[2]];   // answer for address 2 back
            end
            if (o_madd_wr.we) check_wb();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // load, swap, run
    ////////////////////////////////////////////////////////////////////////////
    // 16 rows x 3 polys with one row of all 8 base banks per beat
    task automatic load_set(input int t);
        for (int p = 0; p < NUM_POLY; p++) begin
            for (int i = 0; i < NUM_COEF; i++) begin
                load_coef[p][i] = draw_value(test_mode[t], 1'b1);
                load_psum[p][i] = draw_value(test_mode[t], 1'b0);
            end
        end
        for (int p = 0; p < NUM_POLY; p++) begin
            for (int row = 0; row < ROWS; row++) begin
                i_axi_wr.we = NUM_BANK'({NUM_BASE_BANK{1'b1}}) << (p * NUM_BASE_BANK);
                for (int b = 0; b < NUM_BASE_BANK; b++) begin
                    i_axi_wr.addr[b] = ADDR_WIDTH'(row);
                    i_axi_wr.data[b] = load_coef[p][row * NUM_BASE_BANK + b];   // idx = {row, bank}
                end
                step;
            end
        end
        i_axi_wr = '0;
    endtask

    task automatic run_entry(input int t);
        if (!preloaded) load_set(t);
        preloaded = 1'b0;
        check_cnt++;
        if (!o_madd_done) begin
            err_cnt++;
            $display("ERROR: %s: done was low before the swap", test_name[t]);
        end
        i_axi_done = 1'b1;
        step;
        i_axi_done = 1'b0;
        check_cnt++;
        if (o_madd_done) begin
            err_cnt++;
            $display("ERROR: %s: done did not fall after the swap", test_name[t]);
        end
        run_coef = load_coef;   // roles exchanged
        psum_tab = load_psum;
        cur_name  = test_name[t];
        wb_count  = 0;
        wb_expect = 1'b1;
        i_madd_start = 1'b1;
        step;
        i_madd_start = 1'b0;
        repeat (10) step;
        i_madd_start = 1'b1;   // mid-run start must be ignored
        step;
        i_madd_start = 1'b0;
        if (test_overlap[t] && (t + 1 < NUM_TESTS)) begin
            load_set(t + 1);   // goes to the load set only
            preloaded = 1'b1;
        end
        while (!o_madd_done) step;
        check_cnt++;
        if (wb_count != NUM_COEF) begin
            report_mismatch("write-back count", 64'(NUM_COEF), 64'(wb_count));
        end else if (last_wb_cycle - first_wb_cycle != NUM_COEF - 1) begin
            err_cnt++;
            $display("ERROR: %s: write-backs were not in consecutive cycles", cur_name);
        end
        if (last_wb_cycle != cycle_cnt - 1) begin
            err_cnt++;
            $display("ERROR: %s: done did not rise the cycle after the last write-back",
                     cur_name);
        end
        wb_expect = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        seed         = 32'h94d3_246d;
        i_arst_n     = 1'b0;
        i_axi_wr     = '0;
        i_axi_done   = 1'b0;
        i_madd_start = 1'b0;
        check_cnt    = 0;
        err_cnt      = 0;
        mismatch_cnt = 0;
        wb_count     = 0;
        wb_expect    = 1'b0;
        preloaded    = 1'b0;
        cur_name     = "reset";

        test_name[0]    = "rand_basic";
        test_mode[0]    = MODE_RAND;
        test_overlap[0] = 1'b0;
        test_name[1]    = "near_q_wrap";
        test_mode[1]    = MODE_NEAR_Q;
        test_overlap[1] = 1'b1;
        test_name[2]    = "overlap_next";
        test_mode[2]    = MODE_RAND;
        test_overlap[2] = 1'b0;
        test_name[3]    = "zero_coef";
        test_mode[3]    = MODE_ZERO;
        test_overlap[3] = 1'b0;

        repeat (16) @(posedge clk);
        #5;
        i_arst_n = 1'b1;

        // idle state out of reset
        check_cnt++;
        if (!o_madd_done || o_madd_wr.we) begin
            err_cnt++;
            $display("ERROR: after reset done=%0b we=%0b, expected done high and we low",
                     o_madd_done, o_madd_wr.we);
        end
        i_madd_start = 1'b1;   // start while done is ignored
        step;
        i_madd_start = 1'b0;
        repeat (8) step;
        check_cnt++;
        if (wb_count != 0 || !o_madd_done) begin
            err_cnt++;
            $display("ERROR: a start while done was high began a run");
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_entry(t);
        end
        repeat (4) step;

        $display("summary: %0d checks, %0d errors, %0d mismatches",
                 check_cnt, err_cnt, mismatch_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== dp_top.f ====
src/dp_cfg_pkg.sv
src/dp_ctrl_pkg.sv
src/dp_madd_fsm.sv
src/dp_addr_counter.sv
src/dp_pingpong_banks.sv
src/dp_mod_add.sv
src/dp_top.sv
dv/dp_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the dp_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module dp_top_tb -f dp_top.f -o dp_top_sim

out="$(./obj_dir/dp_top_sim)"
echo "$out"

if grep -qx "ALL CHECKS PASSED" <<< "$out"; then
    exit 0
else
    exit 1
fi
